/* list.f */
+incdir+tb
logic/traffic_pkg.sv
logic/pattern_generator.sv
logic/pattern_checker.sv
logic/stats_regs.sv
logic/traffic_test_top.sv
tb/traffic_test_tb.sv

/* Bender.yml */
package:
  name: traffic_test

sources:
  - files:
      - logic/traffic_pkg.sv
      - logic/pattern_generator.sv
      - logic/pattern_checker.sv
      - logic/stats_regs.sv
      - logic/traffic_test_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/traffic_test_tb.sv

/* tb/axil_bfm.svh */
// ----------------------------------------------------------------------
// AXI-Lite access tasks and value compare for the traffic tester bench
// Inputs change on the falling edge, responses are taken once valid
// ----------------------------------------------------------------------
`ifndef AXIL_BFM_SVH
`define AXIL_BFM_SVH

// Address and data offered together, then wait for the response
task automatic write_register(
    input  logic [AXIL_ADDR_W-1:0] addr,
    input  logic [AXIL_DATA_W-1:0] data,
    output axil_resp_t             resp
);
    @(negedge aclk);
    wr_req.addr = addr;
    wr_req.data = data;
    awvalid     = 1'b1;
    wvalid      = 1'b1;
    bready      = 1'b1;
    while (!(awready && wready)) begin
        @(negedge aclk);
    end
    @(negedge aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
        @(negedge aclk);
    end
    check_value("awready during write response", 0, awready);
    check_value("wready during write response", 0, wready);
    resp = bresp;
    @(negedge aclk);
    bready = 1'b0;
endtask

task automatic read_register(
    input  logic [AXIL_ADDR_W-1:0] addr,
    output axil_rd_t               rsp
);
    @(negedge aclk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!arready) begin
        @(negedge aclk);
    end
    @(negedge aclk);
    arvalid = 1'b0;
    while (!rvalid) begin
        @(negedge aclk);
    end
    check_value("arready during read response", 0, arready);
    rsp = rd_rsp;
    @(negedge aclk);
    rready = 1'b0;
endtask

task automatic check_value(
    input string       name,
    input logic [63:0] expected,
    input logic [63:0] actual
);
    if (expected !== actual) begin
        $display("Error: %s expected %0h actual %0h", name, expected, actual);
        stop_on_failure();
    end
endtask

`endif

/* tb/traffic_test_tb.sv */
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Traffic tester testbench
// Loops the generated stream back into the checker with random stalls
// and corruption, and checks the counters against a reference model
// ----------------------------------------------------------------------

module traffic_test_tb;
    import traffic_pkg::*;

    localparam int PKT_LEN    = 16;
    localparam int IFG_LEN    = 5;
    localparam int CLK_PERIOD = 8;
    // 40 packets at heavy stalls, plus the register accesses
    localparam int TIMEOUT_CYCLES = 40 * (PKT_LEN * 5 + IFG_LEN) + 600;

    localparam logic [AXIL_ADDR_W-1:0] ADDR_CONTROL = 32'h0000_000c;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_OUTSIDE = 32'h0000_001c;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_FAR     = 32'h0000_0040;

    localparam int CHK_IDLE      = 0;
    localparam int CHK_COMPARE   = 1;
    localparam int CHK_WAIT_LAST = 2;

    logic                   aclk;
    logic                   aresetn;
    axis_beat_t             m_beat;
    logic                   m_valid;
    logic                   m_ready;
    axis_beat_t             s_beat;
    logic                   s_valid;
    logic                   s_ready;
    logic                   awvalid;
    logic                   wvalid;
    axil_wr_t               wr_req;
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    axil_resp_t             bresp;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic                   rvalid;
    axil_rd_t               rd_rsp;
    logic                   rready;

    integer                 seed = 32'hc364_6a99;
    int                     cycles = 0;
    axis_beat_t             loop_q[$];
    int                     pkt_total = 0;
    int                     pkt_target = 0;
    // Generator side of the model
    int                     gen_idx = 0;
    logic [63:0]            gen_exp = PATTERN_SEED;
    logic                   corrupt_en = 1'b0;
    int                     corrupt_mode = 0;
    int                     next_mode = 1;
    int                     corrupt_beat = 0;
    int                     corrupt_bit = 0;
    // Checker side of the model
    int                     chk_state = CHK_IDLE;
    int                     chk_cnt = 0;
    logic [63:0]            chk_exp = '0;
    logic                   chk_ok = 1'b0;
    logic                   hold_set = 1'b0;
    int                     exp_tx = 0;
    int                     exp_rx = 0;
    int                     exp_err = 0;

    traffic_test_top #(
        .PKT_LEN (PKT_LEN),
        .IFG_LEN (IFG_LEN)
    ) dut_i (.*);

    `include "axil_bfm.svh"

    function automatic logic [AXIS_DATA_W-1:0] rotate_right(input logic [AXIS_DATA_W-1:0] word);
        return (word >> 1) | (word << (AXIS_DATA_W - 1));
    endfunction

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Traffic test stopped on a failure");
    endtask

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    // ------------------------------------------------------------------
    // Model of the generator and of the loopback corruption
    // ------------------------------------------------------------------
    task automatic capture_beat(input axis_beat_t beat);
        axis_beat_t sent;
        check_value("generator data", gen_exp, beat.data);
        check_value("generator tlast", gen_idx == PKT_LEN - 1, beat.last);
        if (gen_idx == 0) begin
            corrupt_mode = 0;
            // Last packet of a run stays clean so the checker closes
            if (corrupt_en && pkt_total < pkt_target - 1) begin
                corrupt_mode = next_mode;
                next_mode    = (next_mode + 1) % 4;
                corrupt_beat = {$random(seed)} % (PKT_LEN - 1);
                corrupt_bit  = {$random(seed)} % AXIS_DATA_W;
            end
        end
        sent = beat;
        // Modes 1 to 3 flip a bit, add an early tlast, drop tlast
        if (corrupt_mode == 1 && gen_idx == corrupt_beat) begin
            sent.data[corrupt_bit] = ~sent.data[corrupt_bit];
        end
        if (corrupt_mode == 2 && gen_idx == corrupt_beat) begin
            sent.last = 1'b1;
        end
        if (corrupt_mode == 3 && gen_idx == PKT_LEN - 1) begin
            sent.last = 1'b0;
        end
        loop_q.push_back(sent);
        gen_exp = rotate_right(gen_exp);
        gen_idx++;
        if (gen_idx == PKT_LEN) begin
            gen_idx   = 0;
            gen_exp   = PATTERN_SEED;
            pkt_total = pkt_total + 1;
            if (!hold_set) begin
                exp_tx++;
            end
        end
    endtask

    // Grades the received stream by the rotation and length rules
    task automatic grade_beat(input axis_beat_t beat);
        logic closing;
        logic good;
        closing = 1'b0;
        good    = 1'b0;
        case (chk_state)
            CHK_IDLE: begin
                if (beat.last) begin
                    closing = 1'b1;
                end else begin
                    chk_exp   = rotate_right(beat.data);
                    chk_cnt   = 1;
                    chk_ok    = 1'b1;
                    chk_state = CHK_COMPARE;
                end
            end
            CHK_COMPARE: begin
                if (beat.last) begin
                    closing   = 1'b1;
                    good      = chk_ok && beat.data == chk_exp && chk_cnt == PKT_LEN - 1;
                    chk_state = CHK_IDLE;
                end else if (chk_cnt == PKT_LEN - 1) begin
                    chk_state = CHK_WAIT_LAST;
                end else begin
                    chk_ok  = chk_ok && beat.data == chk_exp;
                    chk_exp = rotate_right(chk_exp);
                    chk_cnt++;
                end
            end
            default: begin
                if (beat.last) begin
                    closing   = 1'b1;
                    chk_state = CHK_IDLE;
                end
            end
        endcase
        if (closing && !hold_set) begin
            if (good) begin
                exp_rx++;
            end else begin
                exp_err++;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Loopback with random stalls
    // ------------------------------------------------------------------
    initial begin
        m_ready = 1'b0;
        s_valid = 1'b0;
        s_beat  = '0;
        wait (aresetn === 1'b1);
        forever begin
            @(negedge aclk);
            check_value("checker ready", 1, s_ready);
            if (!(s_valid && !s_ready)) begin
                s_valid = 1'b0;
                if (loop_q.size() > 0 && {$random(seed)} % 10 < 8) begin
                    s_beat  = loop_q[0];
                    s_valid = 1'b1;
                end
            end
            if (s_valid && s_ready) begin
                grade_beat(loop_q.pop_front());
            end
            m_ready = (pkt_total < pkt_target) && ({$random(seed)} % 10 < 7);
            if (m_valid && m_ready) begin
                capture_beat(m_beat);
            end
        end
    end

    task automatic wait_drain();
        while (loop_q.size() > 0) begin
            @(negedge aclk);
        end
        repeat (3) @(negedge aclk);
    endtask

    task automatic run_packets(input int count, input logic corrupt);
        corrupt_en = corrupt;
        pkt_target = pkt_total + count;
        while (pkt_total < pkt_target) begin
            @(negedge aclk);
        end
        wait_drain();
    endtask

    task automatic check_counts(input string phase);
        axil_rd_t rsp;
        int       expected[3];
        expected = '{exp_tx, exp_rx, exp_err};
        for (int i = 0; i < 3; i++) begin
            read_register(AXIL_ADDR_W'(i * 4), rsp);
            check_value($sformatf("%s count word %0d", phase, i), expected[i], rsp.data);
            check_value($sformatf("%s resp word %0d", phase, i), RESP_OKAY, rsp.resp);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        axil_rd_t   rsp;
        axil_resp_t resp;
        int         hold_start;
        aresetn = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wr_req  = '0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        run_packets(8, 1'b0);
        check_counts("clean loopback");
        run_packets(12, 1'b1);
        check_counts("corrupted loopback");

        // Map decode and error responses
        read_register(ADDR_CONTROL, rsp);
        check_value("control read data", 0, rsp.data);
        check_value("control read resp", RESP_OKAY, rsp.resp);
        read_register(ADDR_FAR, rsp);
        check_value("outside read data", 0, rsp.data);
        check_value("outside read resp", RESP_SLVERR, rsp.resp);
        write_register(ADDR_OUTSIDE, 32'h1, resp);
        check_value("outside write resp", RESP_SLVERR, resp);
        write_register(32'h0, 32'h1234, resp);
        check_value("count write resp", RESP_SLVERR, resp);
        read_register(ADDR_CONTROL, rsp);
        check_value("control after bad writes", 0, rsp.data);
        check_counts("after bad writes");

        // Hold while a packet is waiting to start
        while (!m_valid) begin
            @(negedge aclk);
        end
        write_register(ADDR_CONTROL, 32'h1, resp);
        check_value("hold set resp", RESP_OKAY, resp);
        hold_set = 1'b1;
        exp_tx   = 0;
        exp_rx   = 0;
        exp_err  = 0;
        check_counts("hold set");
        read_register(ADDR_CONTROL, rsp);
        check_value("control hold data", 1, rsp.data);
        check_value("control hold resp", RESP_OKAY, rsp.resp);
        hold_start = pkt_total;
        pkt_target = pkt_total + 4;
        while (pkt_total == hold_start) begin
            @(negedge aclk);
        end
        repeat (IFG_LEN * 8) @(negedge aclk);
        check_value("packets sent during hold", hold_start + 1, pkt_total);
        check_value("generator idle during hold", 0, m_valid);
        pkt_target = pkt_total;
        wait_drain();
        check_counts("hold after traffic");

        write_register(ADDR_CONTROL, 32'h0, resp);
        check_value("hold clear resp", RESP_OKAY, resp);
        hold_set = 1'b0;
        run_packets(6, 1'b0);
        check_counts("resumed");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/traffic_test_top.sv */
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Traffic tester top level
// Pattern generator, pattern checker and statistics registers
// ----------------------------------------------------------------------

module traffic_test_top #(
    parameter int PKT_LEN = 16,
    parameter int IFG_LEN = 5
) (
    input  wire                                aclk,
    input  wire                                aresetn,
    // Stream out
    output traffic_pkg::axis_beat_t            m_beat,
    output logic                               m_valid,
    input  wire                                m_ready,
    // Stream in
    input  wire traffic_pkg::axis_beat_t       s_beat,
    input  wire                                s_valid,
    output logic                               s_ready,
    // AXI-Lite
    input  wire                                awvalid,
    input  wire                                wvalid,
    input  wire traffic_pkg::axil_wr_t         wr_req,
    output logic                               awready,
    output logic                               wready,
    output logic                               bvalid,
    output traffic_pkg::axil_resp_t            bresp,
    input  wire                                bready,
    input  wire [traffic_pkg::AXIL_ADDR_W-1:0] araddr,
    input  wire                                arvalid,
    output logic                               arready,
    output logic                               rvalid,
    output traffic_pkg::axil_rd_t              rd_rsp,
    input  wire                                rready
);

    logic pkt_sent;
    logic pkt_good;
    logic pkt_bad;
    logic hold;

    pattern_generator #(
        .PKT_LEN (PKT_LEN),
        .IFG_LEN (IFG_LEN)
    ) gen_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .hold     (hold),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .pkt_sent (pkt_sent)
    );

    pattern_checker #(
        .PKT_LEN (PKT_LEN)
    ) chk_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_beat   (s_beat),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .pkt_good (pkt_good),
        .pkt_bad  (pkt_bad)
    );

    stats_regs regs_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .awvalid  (awvalid),
        .wvalid   (wvalid),
        .wr_req   (wr_req),
        .awready  (awready),
        .wready   (wready),
        .bvalid   (bvalid),
        .bresp    (bresp),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rvalid   (rvalid),
        .rd_rsp   (rd_rsp),
        .rready   (rready),
        .pkt_sent (pkt_sent),
        .pkt_good (pkt_good),
        .pkt_bad  (pkt_bad),
        .hold     (hold)
    );

endmodule

`default_nettype wire

/* logic/stats_regs.sv */
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Statistics registers
// AXI4-Lite slave with tx, good and bad packet counters and the hold
// bit that clears the counts and pauses the generator
// ----------------------------------------------------------------------

module stats_regs (
    input  wire                                aclk,
    input  wire                                aresetn,
    // Write channels
    input  wire                                awvalid,
    input  wire                                wvalid,
    input  wire traffic_pkg::axil_wr_t         wr_req,
    output logic                               awready,
    output logic                               wready,
    output logic                               bvalid,
    output traffic_pkg::axil_resp_t            bresp,
    input  wire                                bready,
    // Read channels
    input  wire [traffic_pkg::AXIL_ADDR_W-1:0] araddr,
    input  wire                                arvalid,
    output logic                               arready,
    output logic                               rvalid,
    output traffic_pkg::axil_rd_t              rd_rsp,
    input  wire                                rready,
    // Packet events
    input  wire                                pkt_sent,
    input  wire                                pkt_good,
    input  wire                                pkt_bad,
    output logic                               hold
);
    import traffic_pkg::*;

    // Counters indexed by their register word
    logic [2:0][CNT_W-1:0] count;
    logic [2:0]            pulse;
    logic                  wr_accept;
    logic                  wr_ctrl;
    logic                  rd_accept;
    axil_rd_t              rd_next;

    assign pulse[REG_TX_COUNT]  = pkt_sent;
    assign pulse[REG_RX_COUNT]  = pkt_good;
    assign pulse[REG_ERR_COUNT] = pkt_bad;

    // ------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------
    assign awready   = !bvalid;
    assign wready    = !bvalid;
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign wr_ctrl   = (wr_req.addr < REG_SPAN) && (wr_req.addr[3:2] == REG_CONTROL);

    assign arready   = !rvalid;
    assign rd_accept = arvalid && !rvalid;

    always_comb begin
        rd_next.data = '0;
        rd_next.resp = RESP_OKAY;
        if (araddr >= REG_SPAN) begin
            rd_next.resp = RESP_SLVERR;
        end else if (araddr[3:2] == REG_CONTROL) begin
            rd_next.data = AXIL_DATA_W'(hold);
        end else begin
            rd_next.data = AXIL_DATA_W'(count[araddr[3:2]]);
        end
    end

    // ------------------------------------------------------------------
    // Response handshakes and control bit
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            hold   <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_accept && wr_ctrl) begin
                hold <= wr_req.data[0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_accept) begin
            bresp <= wr_ctrl ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_accept) begin
            rd_rsp <= rd_next;
        end
    end

    // Counts sit at zero while held, events dropped
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else if (hold) begin
            count <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (pulse[i]) begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rd_rsp));

endmodule

`default_nettype wire

/* logic/pattern_checker.sv */
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Pattern checker
// Grades packets on an AXI-Stream slave against the rotate-right rule
// and the fixed packet length, one good or bad pulse per packet
// ----------------------------------------------------------------------

module pattern_checker #(
    parameter int PKT_LEN = 16
) (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire traffic_pkg::axis_beat_t s_beat,
    input  wire                     s_valid,
    output logic                    s_ready,
    output logic                    pkt_good,
    output logic                    pkt_bad
);
    import traffic_pkg::*;

    localparam int BEAT_W = $clog2(PKT_LEN + 1);

    typedef enum logic [1:0] {
        CK_IDLE      = 2'b00,
        CK_COMPARE   = 2'b01,
        CK_WAIT_LAST = 2'b10,
        CK_FINISH    = 2'b11
    } chk_state_t;

    chk_state_t             state;
    logic [AXIS_DATA_W-1:0] expected;
    logic [BEAT_W-1:0]      beat_cnt;
    logic                   ok;
    logic                   beat_xfer;
    logic                   opening;
    logic                   at_len;
    logic                   data_match;

    assign beat_xfer  = s_valid && s_ready;
    // Finish doubles as idle so a back-to-back packet is taken
    assign opening    = beat_xfer && (state == CK_IDLE || state == CK_FINISH);
    assign at_len     = (beat_cnt == BEAT_W'(PKT_LEN - 1));
    assign data_match = (s_beat.data == expected);

    assign pkt_good = (state == CK_FINISH) && ok;
    assign pkt_bad  = (state == CK_FINISH) && !ok;

    // ------------------------------------------------------------------
    // Grading FSM
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= CK_IDLE;
            beat_cnt <= '0;
            ok       <= 1'b1;
            s_ready  <= 1'b0;
        end else begin
            s_ready <= 1'b1;
            case (state)
                CK_IDLE, CK_FINISH: begin
                    if (beat_xfer) begin
                        beat_cnt <= BEAT_W'(1);
                        if (s_beat.last) begin
                            // Single beat closes early
                            ok    <= 1'b0;
                            state <= CK_FINISH;
                        end else begin
                            ok    <= 1'b1;
                            state <= CK_COMPARE;
                        end
                    end else begin
                        state <= CK_IDLE;
                    end
                end
                CK_COMPARE: begin
                    if (beat_xfer) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (s_beat.last) begin
                            ok    <= ok && data_match && at_len;
                            state <= CK_FINISH;
                        end else if (at_len) begin
                            // Length reached without tlast
                            ok    <= 1'b0;
                            state <= CK_WAIT_LAST;
                        end else begin
                            ok <= ok && data_match;
                        end
                    end
                end
                CK_WAIT_LAST: begin
                    if (beat_xfer && s_beat.last) begin
                        state <= CK_FINISH;
                    end
                end
                default: state <= CK_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (opening) begin
            expected <= rotr1(s_beat.data);
        end else if (beat_xfer) begin
            expected <= rotr1(expected);
        end
    end

    // One grade per packet, right after a closing beat
    a_one_grade: assert property (@(posedge aclk) disable iff (!aresetn)
        (pkt_good || pkt_bad) |-> !(pkt_good && pkt_bad) && $past(beat_xfer && s_beat.last));

endmodule

`default_nettype wire

/* logic/pattern_generator.sv */
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// Pattern generator
// Sends fixed-length rotating-pattern packets on an AXI-Stream master
// with a fixed idle gap, and pauses at a gap while hold is set
// ----------------------------------------------------------------------

module pattern_generator #(
    parameter int PKT_LEN = 16,
    parameter int IFG_LEN = 5
) (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire                     hold,
    output traffic_pkg::axis_beat_t m_beat,
    output logic                    m_valid,
    input  wire                     m_ready,
    output logic                    pkt_sent
);
    import traffic_pkg::*;

    localparam int BEAT_W = $clog2(PKT_LEN + 1);
    localparam int GAP_W  = $clog2(IFG_LEN + 1);

    typedef enum logic {
        ST_GAP,
        ST_PKT
    } gen_state_t;

    gen_state_t             state;
    logic [BEAT_W-1:0]      beat_cnt;
    logic [GAP_W-1:0]       gap_cnt;
    logic [AXIS_DATA_W-1:0] rot_word;
    logic                   last_beat;
    logic                   gap_done;
    logic                   beat_xfer;

    assign last_beat = (beat_cnt == BEAT_W'(PKT_LEN - 1));
    assign gap_done  = (gap_cnt == GAP_W'(IFG_LEN - 1));
    assign beat_xfer = m_valid && m_ready;

    assign m_valid     = (state == ST_PKT);
    assign m_beat.data = rot_word;
    assign m_beat.last = last_beat;
    assign pkt_sent    = beat_xfer && last_beat;

    // ------------------------------------------------------------------
    // Gap / packet sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= ST_GAP;
            gap_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_GAP: begin
                    // Gap runs every cycle, then waits here while held
                    if (gap_done) begin
                        if (!hold) begin
                            state    <= ST_PKT;
                            beat_cnt <= '0;
                        end
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                ST_PKT: begin
                    if (beat_xfer) begin
                        if (last_beat) begin
                            state   <= ST_GAP;
                            gap_cnt <= '0;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= ST_GAP;
            endcase
        end
    end

    // Seed reloads through the whole gap
    always_ff @(posedge aclk) begin
        if (state == ST_GAP) begin
            rot_word <= PATTERN_SEED;
        end else if (beat_xfer) begin
            rot_word <= rotr1(rot_word);
        end
    end

    // Stalled beat stays offered and unchanged
    a_beat_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

`default_nettype wire

/* logic/traffic_pkg.sv */
`default_nettype none
// ----------------------------------------------------------------------
// Traffic tester shared definitions
// Stream and AXI-Lite widths, pattern seed, register map, response
// codes and the beat and bus structs used across the tester
// ----------------------------------------------------------------------

package traffic_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int AXIS_DATA_W = 64;
    localparam int CNT_W       = 32;
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;

    // First beat of every generated packet
    localparam logic [AXIS_DATA_W-1:0] PATTERN_SEED = 64'hcafe_beef_cafe_beef;

    // ------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------
    // Word index taken from address bits 3:2
    localparam logic [1:0] REG_TX_COUNT  = 2'd0;
    localparam logic [1:0] REG_RX_COUNT  = 2'd1;
    localparam logic [1:0] REG_ERR_COUNT = 2'd2;
    localparam logic [1:0] REG_CONTROL   = 2'd3;

    // Byte addresses at or above this fall outside the map
    localparam logic [AXIL_ADDR_W-1:0] REG_SPAN = 32'd16;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // ------------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------------
    // One stream beat, tdata plus tlast
    typedef struct packed {
        logic [AXIS_DATA_W-1:0] data;
        logic                   last;
    } axis_beat_t;

    // Write address and data, taken together
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
        logic [AXIL_DATA_W-1:0] data;
    } axil_wr_t;

    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_t             resp;
    } axil_rd_t;

    // Pattern step, rotate right by one bit
    function automatic logic [AXIS_DATA_W-1:0] rotr1(input logic [AXIS_DATA_W-1:0] word);
        return {word[0], word[AXIS_DATA_W-1:1]};
    endfunction

endpackage

`default_nettype wire
